// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing -j 0
TOP       = seq_mult_tb
FILELIST  = seq_mult.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/mult_pkg.sv
//==========================================================
// Shared types of the signed sequential multiplier
// Controller state encoding and the control strobe bundle
//==========================================================

package mult_pkg;

	//==========================================================
	// Controller states
	//==========================================================

	// Four states cover one whole multiplication
	// The encoding is kept at two bits so it shows up cleanly in waves
	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		SWEEP = 2'd1,
		FIX   = 2'd2,
		DONE  = 2'd3
	} mult_state_t;

	//==========================================================
	// Control strobes from the FSM to the datapath
	//==========================================================

	// Load captures the operands and clears the sweep
	// Step advances the sweep by one multiplier bit
	// Fix applies the result sign and registers the product
	typedef struct packed {
		logic load;
		logic step;
		logic fix;
	} mult_ctrl_t;

endpackage

// File: hdl/mult_control.sv
//==========================================================
// Multiplier controller
// Sequences load, bit sweep, sign fix and the done pulse
//==========================================================
`timescale 1ns/1ps

module mult_control
	import mult_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       start,
	input  logic       sweep_last,
	output mult_ctrl_t ctrl,
	output logic       busy,
	output logic       done
);

	mult_state_t state;
	mult_state_t state_next;

	//==========================================================
	// State register
	//==========================================================

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			state <= IDLE;
		end
		else
		begin
			state <= state_next;
		end
	end

	// The FSM does not count bits on its own
	// It waits for the sweep adder to flag the last multiplier bit
	always_comb
	begin
		state_next = state;
		case (state)
			IDLE:
			begin
				if (start)
					state_next = SWEEP;
			end
			SWEEP:
			begin
				if (sweep_last)
					state_next = FIX;
			end
			FIX:
			begin
				state_next = DONE;
			end
			default:
			begin
				state_next = IDLE;
			end
		endcase
	end

	//==========================================================
	// Output decode
	//==========================================================

	// Load is a direct decode of start in IDLE so the operands land on the accepting edge
	assign ctrl.load = (state == IDLE) && start;
	assign ctrl.step = (state == SWEEP);
	assign ctrl.fix  = (state == FIX);

	// Busy covers everything from the first sweep step through the done cycle
	assign busy = (state != IDLE);
	assign done = (state == DONE);

endmodule

// File: hdl/seq_mult.sv
//==========================================================
// Signed sequential multiplier
// Multiplies two DW-bit signed operands into a 2*DW-bit product
//==========================================================
`timescale 1ns/1ps

module seq_mult
	import mult_pkg::*;
#(
	parameter int DW = 8
)
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   start,
	input  logic signed [DW-1:0]   multiplier,
	input  logic signed [DW-1:0]   multiplicand,
	output logic                   busy,
	output logic                   done,
	output logic signed [2*DW-1:0] product
);

	//==========================================================
	// Internal wiring
	//==========================================================

	mult_ctrl_t      ctrl;
	logic            sweep_last;
	logic [DW-1:0]   multiplier_mag;
	logic [DW-1:0]   multiplicand_mag;
	logic [2*DW-1:0] shifted;
	logic [2*DW-1:0] sum;

	// Controller
	mult_control u_control (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.sweep_last (sweep_last),
		.ctrl       (ctrl),
		.busy       (busy),
		.done       (done)
	);

	// Magnitudes in, signed product out
	sign_unit #(
		.DW (DW)
	) u_sign (
		.clk              (clk),
		.rst              (rst),
		.ctrl             (ctrl),
		.multiplier       (multiplier),
		.multiplicand     (multiplicand),
		.sum              (sum),
		.multiplier_mag   (multiplier_mag),
		.multiplicand_mag (multiplicand_mag),
		.product          (product)
	);

	// Moving addend for the sweep
	multiplicand_shifter #(
		.DW (DW)
	) u_shifter (
		.clk              (clk),
		.rst              (rst),
		.ctrl             (ctrl),
		.multiplicand_mag (multiplicand_mag),
		.shifted          (shifted)
	);

	sweep_adder #(
		.DW (DW)
	) u_sweep (
		.clk            (clk),
		.rst            (rst),
		.ctrl           (ctrl),
		.multiplier_mag (multiplier_mag),
		.shifted        (shifted),
		.sum            (sum),
		.sweep_last     (sweep_last)
	);

endmodule

// File: hdl/sign_unit.sv
//==========================================================
// Sign handling for the multiplier
// Turns the operands into magnitudes, keeps the result sign
// and registers the final signed product
//==========================================================
`timescale 1ns/1ps

module sign_unit
	import mult_pkg::*;
#(
	parameter int DW = 8
)
(
	input  logic                   clk,
	input  logic                   rst,
	input  mult_ctrl_t             ctrl,
	input  logic signed [DW-1:0]   multiplier,
	input  logic signed [DW-1:0]   multiplicand,
	input  logic [2*DW-1:0]        sum,
	output logic [DW-1:0]          multiplier_mag,
	output logic [DW-1:0]          multiplicand_mag,
	output logic signed [2*DW-1:0] product
);

	// Set when exactly one operand is negative
	logic neg;

	//==========================================================
	// Operand capture
	//==========================================================

	// The most negative operand negates to itself in DW bits
	// Read as unsigned that pattern is exactly 2**(DW-1), so no extra bit is needed
	// The shifter captures the multiplicand magnitude on the load edge itself
	// It therefore comes straight from the live operand and is held in the shifter
	assign multiplicand_mag = multiplicand[DW-1] ? -multiplicand : multiplicand;

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			multiplier_mag <= '0;
			neg            <= 1'b0;
		end
		else if (ctrl.load)
		begin
			multiplier_mag <= multiplier[DW-1] ? -multiplier : multiplier;
			neg            <= multiplier[DW-1] ^ multiplicand[DW-1];
		end
	end

	//==========================================================
	// Product register
	//==========================================================

	// The product only changes on fix and holds across idle cycles
	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
			product <= '0;
		else if (ctrl.fix)
			product <= neg ? -sum : sum;
	end

endmodule

// File: seq_mult.f
common/mult_pkg.sv
hdl/mult_control.sv
hdl/sign_unit.sv
sweep_adder/multiplicand_shifter.sv
sweep_adder/sweep_adder.sv
hdl/seq_mult.sv
verification/tb_clock.sv
verification/seq_mult_tb.sv

// File: sweep_adder/multiplicand_shifter.sv
//==========================================================
// Multiplicand shifter
// Presents the multiplicand magnitude times 2**k at step k
//==========================================================
`timescale 1ns/1ps

module multiplicand_shifter
	import mult_pkg::*;
#(
	parameter int DW = 8
)
(
	input  logic             clk,
	input  logic             rst,
	input  mult_ctrl_t       ctrl,
	input  logic [DW-1:0]    multiplicand_mag,
	output logic [2*DW-1:0]  shifted
);

	// Twice the operand width leaves room for DW-1 left shifts of a full magnitude
	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			shifted <= '0;
		end
		else if (ctrl.load)
		begin
			// Zero extension because the value is already a magnitude
			shifted <= {{DW{1'b0}}, multiplicand_mag};
		end
		else if (ctrl.step)
		begin
			shifted <= {shifted[2*DW-2:0], 1'b0};
		end
	end

endmodule

// File: sweep_adder/sweep_adder.sv
//==========================================================
// Bit sweep accumulator
// Walks the multiplier one bit per clock and adds the
// shifted multiplicand wherever that bit is set
//==========================================================
`timescale 1ns/1ps

module sweep_adder
	import mult_pkg::*;
#(
	parameter int DW = 8
)
(
	input  logic            clk,
	input  logic            rst,
	input  mult_ctrl_t      ctrl,
	input  logic [DW-1:0]   multiplier_mag,
	input  logic [2*DW-1:0] shifted,
	output logic [2*DW-1:0] sum,
	output logic            sweep_last
);

	localparam int CW = $clog2(DW);
	localparam logic [CW-1:0] LAST = CW'(DW - 1);

	// Index of the multiplier bit handled in the current step
	logic [CW-1:0] count;

	//==========================================================
	// Counter and accumulator
	//==========================================================

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			count <= '0;
			sum   <= '0;
		end
		else if (ctrl.load)
		begin
			count <= '0;
			sum   <= '0;
		end
		else if (ctrl.step)
		begin
			// A zero bit still costs a full cycle so the latency never varies
			count <= count + 1'b1;
			if (multiplier_mag[count])
				sum <= sum + shifted;
		end
	end

	// Flags the step that handles the top magnitude bit
	// This is the only place that counts, so the FSM takes its exit from here
	assign sweep_last = ctrl.step && (count == LAST);

endmodule

// File: verification/seq_mult_tb.sv
//==========================================================
// Testbench of the signed sequential multiplier
// Random and corner operands checked against a product model
//==========================================================
`timescale 1ns/1ps

module seq_mult_tb
	import mult_pkg::*;
();

	localparam int DW = 8;
	localparam int PW = 2 * DW;
	localparam int TIMEOUT = 4 * DW + 8;
	localparam int NUM_RANDOM = 300;

	logic                   clk;
	logic                   rst;
	logic                   start;
	logic signed [DW-1:0]   multiplier;
	logic signed [DW-1:0]   multiplicand;
	logic                   busy;
	logic                   done;
	logic signed [PW-1:0]   product;
	logic [31:0]            rng_state;
	logic signed [DW-1:0]   corners [0:4];
	logic signed [DW-1:0]   op_a;
	logic signed [DW-1:0]   op_b;

	tb_clock #(.HALF_PERIOD(50), .RESET_CYCLES(16)) u_clock (.clk(clk), .rst(rst));

	seq_mult #(
		.DW (DW)
	) uut (
		.clk          (clk),
		.rst          (rst),
		.start        (start),
		.multiplier   (multiplier),
		.multiplicand (multiplicand),
		.busy         (busy),
		.done         (done),
		.product      (product)
	);

	//==========================================================
	// Stimulus source and reference model
	//==========================================================

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic next_operand(output logic signed [DW-1:0] value);
		rng_state = xorshift32(rng_state);
		value = rng_state[DW-1:0];
	endtask

	// Plain signed multiply of the sign extended operands
	function automatic logic signed [PW-1:0] model_product(input logic signed [DW-1:0] a,
			input logic signed [DW-1:0] b);
		logic signed [PW-1:0] wa;
		logic signed [PW-1:0] wb;
		wa = {{DW{a[DW-1]}}, a};
		wb = {{DW{b[DW-1]}}, b};
		return wa * wb;
	endfunction

	//==========================================================
	// Checks
	//==========================================================

	task automatic report_fail(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_product(input string name, input logic signed [PW-1:0] expected,
			input logic signed [PW-1:0] actual);
		if (actual !== expected)
			report_fail($sformatf("ERR time=%0t %s expected=%0d actual=%0d",
				$time, name, expected, actual));
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			report_fail($sformatf("ERR time=%0t %s expected=%b actual=%b",
				$time, name, expected, actual));
	endtask

	task automatic wait_reset();
		int n;
		n = 0;
		while (rst !== 1'b1)
		begin
			@(negedge clk);
			n++;
			if (n > 64)
				report_fail("reset was never released");
		end
	endtask

	// Idle cycles with the operands moving and no start, the product must hold
	task automatic hold_idle(input int cycles, input logic signed [PW-1:0] expected);
		repeat (cycles)
		begin
			@(negedge clk);
			start = 1'b0;
			next_operand(multiplier);
			next_operand(multiplicand);
			check_flag("busy", 1'b0, busy);
			check_flag("done", 1'b0, done);
			check_product("product", expected, product);
		end
	endtask

	// One multiplication from idle, optionally with a second start during the sweep
	task automatic run_mult(input logic signed [DW-1:0] a, input logic signed [DW-1:0] b,
			input bit intrude);
		logic signed [PW-1:0] expected;
		mult_state_t          state_now;
		int                   edges;
		bit                   done_seen;
		expected = model_product(a, b);
		@(negedge clk);
		check_flag("busy", 1'b0, busy);
		start = 1'b1;
		multiplier = a;
		multiplicand = b;
		// Edge 0 accepts the start
		@(negedge clk);
		start = 1'b0;
		check_flag("busy", 1'b1, busy);
		check_flag("done", 1'b0, done);
		edges = 0;
		done_seen = 1'b0;
		while (!done_seen)
		begin
			@(posedge clk);
			edges++;
			@(negedge clk);
			start = 1'b0;
			if (intrude && edges == 3)
			begin
				start = 1'b1;
				next_operand(multiplier);
				next_operand(multiplicand);
			end
			check_flag("busy", 1'b1, busy);
			if (done)
				done_seen = 1'b1;
			else if (edges > TIMEOUT)
			begin
				state_now = mult_state_t'(uut.u_control.state);
				report_fail($sformatf("no done pulse within %0d cycles, FSM in %s",
					TIMEOUT, state_now.name()));
			end
		end
		if (edges != DW + 1)
			report_fail($sformatf("done rose %0d edges after start instead of %0d",
				edges, DW + 1));
		check_product("product", expected, product);
		// Done lasts one cycle and busy drops with it
		@(negedge clk);
		check_flag("done", 1'b0, done);
		check_flag("busy", 1'b0, busy);
		check_product("product", expected, product);
	endtask

	//==========================================================
	// Test sequence
	//==========================================================

	initial
	begin
		start = 1'b0;
		multiplier = '0;
		multiplicand = '0;
		rng_state = 32'h2aa0_5ccd;
		corners[0] = '0;
		corners[1] = DW'(1);
		corners[2] = '1;
		corners[3] = {1'b0, {(DW-1){1'b1}}};
		corners[4] = {1'b1, {(DW-1){1'b0}}};
		wait_reset();
		// Quiet after reset
		hold_idle(8, '0);
		for (int i = 0; i < NUM_RANDOM; i++)
		begin
			next_operand(op_a);
			next_operand(op_b);
			run_mult(op_a, op_b, 1'b0);
		end
		for (int i = 0; i < 5; i++)
			for (int j = 0; j < 5; j++)
				run_mult(corners[i], corners[j], 1'b0);
		// A second start during the sweep must be dropped
		for (int i = 0; i < 10; i++)
		begin
			next_operand(op_a);
			next_operand(op_b);
			run_mult(op_a, op_b, 1'b1);
		end
		next_operand(op_a);
		next_operand(op_b);
		run_mult(op_a, op_b, 1'b0);
		hold_idle(12, model_product(op_a, op_b));
		run_mult(corners[4], corners[3], 1'b0);
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// File: verification/tb_clock.sv
//==========================================================
// Testbench clock and reset source
// 100 ns clock, active low reset held for 16 cycles
//==========================================================
`timescale 1ns/1ps

module tb_clock #(
	parameter int HALF_PERIOD  = 50,
	parameter int RESET_CYCLES = 16
)
(
	output logic clk,
	output logic rst
);

	initial
	begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// Reset lets go on a falling edge, well away from the rising edge the flops use
	initial
	begin
		rst = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;
	end

endmodule
